/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_fields_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] F7_BASE   = 7'h00;
    localparam logic [6:0] F7_ALT    = 7'h20; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'h01;

    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SR      = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND, OP_LUI
    } op_t;

    // mul and div units decode their own low codes
    localparam op_t OP_MUL    = OP_ADD;
    localparam op_t OP_MULH   = OP_SUB;
    localparam op_t OP_MULHSU = OP_SLL;
    localparam op_t OP_MULHU  = OP_SLT;
    localparam op_t OP_DIV    = OP_ADD;
    localparam op_t OP_DIVU   = OP_SUB;
    localparam op_t OP_REM    = OP_SLL;
    localparam op_t OP_REMU   = OP_SLT;

endpackage

`default_nettype wire

/* sb_pkg.sv */
`default_nettype none

package sb_pkg;

    localparam int NUM_FU = 3;

    // lower id wins every arbitration
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MUL  = 2'd2,
        FU_DIV  = 2'd3
    } fu_id_t;

    typedef logic [NUM_FU:0] fu_vec_t; // bit 0 unused

    typedef struct packed {
        logic                 valid;
        fu_id_t               fu;
        rv_isa_pkg::op_t      op;
        logic                 use_imm;
        rv_isa_pkg::reg_idx_t dst;
        rv_isa_pkg::reg_idx_t src1;
        rv_isa_pkg::reg_idx_t src2;
    } issue_req_t;

    typedef struct packed {
        logic                 busy;
        rv_isa_pkg::op_t      op;
        logic                 use_imm;
        rv_isa_pkg::reg_idx_t dst;
        rv_isa_pkg::reg_idx_t src1;
        rv_isa_pkg::reg_idx_t src2;
        fu_id_t               fu1;  // producer of src1 at issue
        fu_id_t               fu2;
        logic                 rdy1;
        logic                 rdy2;
        logic                 read; // operands taken
        logic                 done;
    } fu_status_t;

    typedef struct packed {
        logic                 valid;
        fu_id_t               fu;
        rv_isa_pkg::op_t      op;
        logic                 use_imm;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
    } ro_grant_t;

    typedef struct packed {
        logic                 valid;
        fu_id_t               fu;
        rv_isa_pkg::reg_idx_t rd;
    } wb_grant_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  rv_isa_pkg::inst_fields_t inst,
    input  logic                     inst_valid,
    output sb_pkg::issue_req_t       req
);
    import rv_isa_pkg::*;
    import sb_pkg::*;

    logic f7_base;
    logic f7_alt;
    logic is_imm;
    logic alu_ok;
    op_t  alu_op;

    assign f7_base = inst.funct7 == F7_BASE;
    assign f7_alt  = inst.funct7 == F7_ALT;
    assign is_imm  = inst.opcode == OPC_OP_IMM;

    // immediate forms ignore funct7 except on shifts
    always_comb begin
        alu_op = OP_ADD;
        alu_ok = f7_base || is_imm;
        case (inst.funct3)
            F3_ADD_SUB: begin
                if (f7_alt && !is_imm) alu_op = OP_SUB;
                alu_ok = f7_base || f7_alt || is_imm;
            end
            F3_SLL: begin
                alu_op = OP_SLL;
                alu_ok = f7_base;
            end
            F3_SLT:  alu_op = OP_SLT;
            F3_SLTU: alu_op = OP_SLTU;
            F3_XOR:  alu_op = OP_XOR;
            F3_SR: begin
                alu_op = OP_SRL;
                if (f7_alt) alu_op = OP_SRA;
                alu_ok = f7_base || f7_alt;
            end
            F3_OR:   alu_op = OP_OR;
            F3_AND:  alu_op = OP_AND;
        endcase
    end

    always_comb begin
        req = '0;
        case (inst.opcode)
            OPC_OP: begin
                req.dst  = inst.rd;
                req.src1 = inst.rs1;
                req.src2 = inst.rs2;
                if (inst.funct7 == F7_MULDIV) begin
                    req.valid = inst_valid;
                    req.fu    = FU_MUL;
                    if (inst.funct3[2]) req.fu = FU_DIV; // upper half is div/rem
                    case (inst.funct3)
                        3'd0: req.op = OP_MUL;
                        3'd1: req.op = OP_MULH;
                        3'd2: req.op = OP_MULHSU;
                        3'd3: req.op = OP_MULHU;
                        3'd4: req.op = OP_DIV;
                        3'd5: req.op = OP_DIVU;
                        3'd6: req.op = OP_REM;
                        3'd7: req.op = OP_REMU;
                    endcase
                end else begin
                    req.valid = inst_valid && alu_ok;
                    req.fu    = FU_ALU;
                    req.op    = alu_op;
                end
            end
            OPC_OP_IMM: begin
                req.valid   = inst_valid && alu_ok;
                req.fu      = FU_ALU;
                req.op      = alu_op;
                req.use_imm = 1'b1;
                req.dst     = inst.rd;
                req.src1    = inst.rs1;
            end
            OPC_LUI: begin
                req.valid   = inst_valid;
                req.fu      = FU_ALU;
                req.op      = OP_LUI;
                req.use_imm = 1'b1;
                req.dst     = inst.rd;
            end
            default: ; // not in the kept set
        endcase
    end

endmodule

`default_nettype wire

/* reg_result_table.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_result_table (
    input  logic               clk,
    input  logic               rst,
    input  sb_pkg::issue_req_t req,
    input  logic               issue_fire,
    input  sb_pkg::wb_grant_t  wb,
    output sb_pkg::fu_id_t     fu1,
    output sb_pkg::fu_id_t     fu2,
    output logic               dst_pending
);
    import sb_pkg::*;

    fu_id_t producer [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                producer[i] <= FU_NONE;
            end
        end else begin
            if (wb.valid) begin
                producer[wb.rd] <= FU_NONE;
            end
            if (issue_fire && req.dst != '0) begin // x0 never pending
                producer[req.dst] <= req.fu;
            end
        end
    end

    assign fu1         = producer[req.src1];
    assign fu2         = producer[req.src2];
    assign dst_pending = req.dst != '0 && producer[req.dst] != FU_NONE;

    // issue lands only on a free slot
    a_slot_free: assert property (@(posedge clk) disable iff (rst)
        issue_fire && req.dst != '0 |-> producer[req.dst] == FU_NONE);

endmodule

`default_nettype wire

/* fu_status_table.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_status_table (
    input  logic               clk,
    input  logic               rst,
    input  sb_pkg::issue_req_t req,
    input  sb_pkg::fu_id_t     fu1,
    input  sb_pkg::fu_id_t     fu2,
    input  logic               dst_pending,
    input  sb_pkg::fu_vec_t    done,
    input  sb_pkg::wb_grant_t  wb,
    output logic               issue_ready,
    output logic               issue_fire,
    output sb_pkg::fu_status_t status [1:sb_pkg::NUM_FU],
    output sb_pkg::ro_grant_t  ro
);
    import sb_pkg::*;

    fu_vec_t busy;
    logic    rdy1_now;
    logic    rdy2_now;

    always_comb begin
        busy = '0;
        for (int i = 1; i <= NUM_FU; i++) begin
            busy[i] = status[i].busy;
        end
    end

    // structural or WAW hazard holds fetch
    assign issue_ready = !(req.valid && (busy[req.fu] || dst_pending));
    assign issue_fire  = req.valid && issue_ready;

    // producer retiring this very cycle counts as written
    assign rdy1_now = fu1 == FU_NONE || (wb.valid && wb.fu == fu1);
    assign rdy2_now = fu2 == FU_NONE || (wb.valid && wb.fu == fu2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i <= NUM_FU; i++) begin
                status[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= NUM_FU; i++) begin
                if (issue_fire && req.fu == i) begin
                    status[i] <= '{busy: 1'b1, op: req.op, use_imm: req.use_imm,
                                   dst: req.dst, src1: req.src1, src2: req.src2,
                                   fu1: fu1, fu2: fu2, rdy1: rdy1_now, rdy2: rdy2_now,
                                   read: 1'b0, done: 1'b0};
                end else if (wb.valid && wb.fu == i) begin
                    status[i] <= '0;
                end else if (status[i].busy) begin
                    if (ro.valid && ro.fu == i) begin
                        status[i].read <= 1'b1;
                    end
                    if (done[i] && status[i].read) begin // early strobes dropped
                        status[i].done <= 1'b1;
                    end
                    // RAW release
                    if (wb.valid && status[i].fu1 == wb.fu) begin
                        status[i].rdy1 <= 1'b1;
                    end
                    if (wb.valid && status[i].fu2 == wb.fu) begin
                        status[i].rdy2 <= 1'b1;
                    end
                end
            end
        end
    end

    // one grant per cycle, alu first
    always_comb begin
        ro = '0;
        for (int i = NUM_FU; i >= 1; i--) begin
            if (status[i].busy && !status[i].read && status[i].rdy1 && status[i].rdy2) begin
                ro.valid   = 1'b1;
                ro.fu      = fu_id_t'(i);
                ro.op      = status[i].op;
                ro.use_imm = status[i].use_imm;
                ro.rs1     = status[i].src1;
                ro.rs2     = status[i].src2;
            end
        end
    end

    // a retiring unit is still busy, so issue to it waits
    a_issue_free: assert property (@(posedge clk) disable iff (rst)
        issue_fire && wb.valid |-> wb.fu != req.fu);

    // operands of a retiring unit were taken long before
    a_ro_single: assert property (@(posedge clk) disable iff (rst)
        ro.valid && wb.valid |-> ro.fu != wb.fu);

endmodule

`default_nettype wire

/* writeback_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_arbiter (
    input  sb_pkg::fu_status_t status [1:sb_pkg::NUM_FU],
    output sb_pkg::wb_grant_t  wb
);
    import sb_pkg::*;

    fu_vec_t can_wb;

    // reader still owes a read of the old value in the writer's destination
    function automatic logic war_hit(fu_status_t rd_e, fu_status_t wr_e, fu_id_t wr_fu);
        logic hit1;
        logic hit2;
        // a source still waiting on this writer wants the new value
        hit1 = rd_e.src1 == wr_e.dst && !(rd_e.fu1 == wr_fu && !rd_e.rdy1);
        hit2 = rd_e.src2 == wr_e.dst && !(rd_e.fu2 == wr_fu && !rd_e.rdy2);
        return rd_e.busy && !rd_e.read && wr_e.dst != '0 && (hit1 || hit2);
    endfunction

    always_comb begin
        can_wb = '0;
        for (int i = 1; i <= NUM_FU; i++) begin
            can_wb[i] = status[i].busy && status[i].done;
            for (int j = 1; j <= NUM_FU; j++) begin
                if (j != i && war_hit(status[j], status[i], fu_id_t'(i))) begin
                    can_wb[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        wb = '0;
        for (int i = NUM_FU; i >= 1; i--) begin
            if (can_wb[i]) begin
                wb.valid = 1'b1;
                wb.fu    = fu_id_t'(i);
                wb.rd    = status[i].dst;
            end
        end
    end

    // done only latches after the operand read
    always_comb begin
        a_wb_done: assert final (!wb.valid || (status[wb.fu].done && status[wb.fu].read));
    end

endmodule

`default_nettype wire

/* scoreboard_top.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreboard_top (
    input  logic                     clk,
    input  logic                     rst,
    input  rv_isa_pkg::inst_fields_t inst,
    input  logic                     inst_valid,
    output logic                     issue_ready,
    input  sb_pkg::fu_vec_t          done,
    output sb_pkg::ro_grant_t        ro,
    output sb_pkg::wb_grant_t        wb
);
    import sb_pkg::*;

    issue_req_t req;
    fu_id_t     fu1;
    fu_id_t     fu2;
    logic       dst_pending;
    logic       issue_fire;
    fu_status_t status [1:NUM_FU];

    inst_decoder inst_decoder_inst (
        .inst       (inst),
        .inst_valid (inst_valid),
        .req        (req)
    );

    reg_result_table reg_result_table_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .issue_fire  (issue_fire),
        .wb          (wb),
        .fu1         (fu1),
        .fu2         (fu2),
        .dst_pending (dst_pending)
    );

    fu_status_table fu_status_table_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .fu1         (fu1),
        .fu2         (fu2),
        .dst_pending (dst_pending),
        .done        (done),
        .wb          (wb),
        .issue_ready (issue_ready),
        .issue_fire  (issue_fire),
        .status      (status),
        .ro          (ro)
    );

    writeback_arbiter writeback_arbiter_inst (
        .status (status),
        .wb     (wb)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0; // same offset as the stimulus
    end

endmodule

`default_nettype wire

/* scoreboard_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreboard_tb;
    import rv_isa_pkg::*;
    import sb_pkg::*;

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTS    = 300;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 * NUM_INSTS) * PERIOD_NS;

    logic         clk;
    logic         rst;
    inst_fields_t inst;
    logic         inst_valid;
    logic         issue_ready;
    fu_vec_t      done;
    ro_grant_t    ro;
    wb_grant_t    wb;

    integer       seed;
    issue_req_t   cur;                // expected decode of inst
    fu_status_t   ent [1:NUM_FU];     // reference status entries
    fu_id_t       prod [32];          // reference producer per register
    logic         pend [1:NUM_FU];    // unit holds operands, owes a done strobe
    int           delay [1:NUM_FU];
    logic         exp_ready;
    ro_grant_t    exp_ro;
    wb_grant_t    exp_wb;
    logic         accept;
    int           sent;
    int           cycle;

    tb_clock_gen tb_clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    scoreboard_top scoreboard_top_inst (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .issue_ready (issue_ready),
        .done        (done),
        .ro          (ro),
        .wb          (wb)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_ro(input string name, input ro_grant_t exp, input ro_grant_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_wb(input string name, input wb_grant_t exp, input wb_grant_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    // small register pool keeps hazards frequent
    function automatic reg_idx_t pick_reg();
        case ({$random(seed)} % 6)
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd2;
            3: return 5'd3;
            4: return 5'd7;
            default: return 5'd31;
        endcase
    endfunction

    function automatic op_t alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? OP_SUB : OP_ADD;
            3'd1: return OP_SLL;
            3'd2: return OP_SLT;
            3'd3: return OP_SLTU;
            3'd4: return OP_XOR;
            3'd5: return alt ? OP_SRA : OP_SRL;
            3'd6: return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    task automatic gen_inst();
        int         kind;
        logic [2:0] f3;
        logic       alt;
        kind = {$random(seed)} % 10;
        alt  = $random(seed);
        inst = inst_fields_t'($random(seed)); // immediate bits stay random
        f3   = inst.funct3;
        cur         = '0;
        cur.valid   = 1'b1;
        cur.fu      = FU_ALU;
        cur.dst     = pick_reg();
        inst.rd     = cur.dst;
        if (kind <= 2) begin
            cur.src1    = pick_reg();
            cur.src2    = pick_reg();
            alt         = alt && (f3 == 3'd0 || f3 == 3'd5);
            inst.opcode = OPC_OP;
            inst.funct7 = alt ? F7_ALT : F7_BASE;
            inst.rs1    = cur.src1;
            inst.rs2    = cur.src2;
            cur.op      = alu_op(f3, alt);
        end else if (kind <= 4) begin
            cur.src1    = pick_reg();
            alt         = alt && f3 == 3'd5;
            inst.opcode = OPC_OP_IMM;
            inst.rs1    = cur.src1;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                inst.funct7 = alt ? F7_ALT : F7_BASE; // shifts take a shamt only
            end
            cur.op      = alu_op(f3, alt);
            cur.use_imm = 1'b1;
        end else if (kind == 5) begin
            inst.opcode = OPC_LUI;
            cur.op      = OP_LUI;
            cur.use_imm = 1'b1;
        end else begin
            cur.src1    = pick_reg();
            cur.src2    = pick_reg();
            inst.opcode = OPC_OP;
            inst.funct7 = F7_MULDIV;
            inst.rs1    = cur.src1;
            inst.rs2    = cur.src2;
            cur.fu      = f3[2] ? FU_DIV : FU_MUL;
            cur.op      = op_t'({2'b00, f3[1:0]});
        end
    endtask

    function automatic logic model_busy();
        for (int u = 1; u <= NUM_FU; u++) begin
            if (ent[u].busy) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // does an unread entry still need the old value of w's destination
    function automatic logic war_blocked(input int w);
        reg_idx_t d;
        logic     old1;
        logic     old2;
        d = ent[w].dst;
        for (int j = 1; j <= NUM_FU; j++) begin
            old1 = ent[j].src1 == d && !(ent[j].fu1 == w && !ent[j].rdy1);
            old2 = ent[j].src2 == d && !(ent[j].fu2 == w && !ent[j].rdy2);
            if (j != w && d != '0 && ent[j].busy && !ent[j].read && (old1 || old2)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic predict_and_check();
        logic hazard;
        hazard = 1'b0;
        if (cur.valid) begin
            hazard = ent[cur.fu].busy || (cur.dst != '0 && prod[cur.dst] != FU_NONE);
        end
        exp_ready = !hazard;
        exp_ro    = '0;
        exp_wb    = '0;
        for (int u = 1; u <= NUM_FU; u++) begin
            if (!exp_ro.valid && ent[u].busy && !ent[u].read && ent[u].rdy1 && ent[u].rdy2) begin
                exp_ro = '{1'b1, fu_id_t'(u), ent[u].op, ent[u].use_imm,
                           ent[u].src1, ent[u].src2};
            end
            if (!exp_wb.valid && ent[u].busy && ent[u].done && !war_blocked(u)) begin
                exp_wb = '{1'b1, fu_id_t'(u), ent[u].dst};
            end
        end
        check_ready($sformatf("issue_ready cycle %0d", cycle), exp_ready, issue_ready);
        check_ro($sformatf("ro cycle %0d", cycle), exp_ro, ro);
        check_wb($sformatf("wb cycle %0d", cycle), exp_wb, wb);
        accept = inst_valid && exp_ready;
    endtask

    // reference state across the rising edge
    task automatic step_model();
        fu_id_t p1;
        fu_id_t p2;
        p1 = prod[cur.src1];
        p2 = prod[cur.src2];
        for (int u = 1; u <= NUM_FU; u++) begin
            if (accept && cur.fu == u) begin
                ent[u]         = '0;
                ent[u].busy    = 1'b1;
                ent[u].op      = cur.op;
                ent[u].use_imm = cur.use_imm;
                ent[u].dst     = cur.dst;
                ent[u].src1    = cur.src1;
                ent[u].src2    = cur.src2;
                ent[u].fu1     = p1;
                ent[u].fu2     = p2;
                // producer retiring this cycle is as good as written
                ent[u].rdy1    = p1 == FU_NONE || (exp_wb.valid && exp_wb.fu == p1);
                ent[u].rdy2    = p2 == FU_NONE || (exp_wb.valid && exp_wb.fu == p2);
            end else if (exp_wb.valid && exp_wb.fu == u) begin
                ent[u] = '0;
            end else if (ent[u].busy) begin
                if (done[u] && ent[u].read) begin
                    ent[u].done = 1'b1;
                end
                if (exp_ro.valid && exp_ro.fu == u) begin
                    ent[u].read = 1'b1;
                end
                if (exp_wb.valid && ent[u].fu1 == exp_wb.fu) begin
                    ent[u].rdy1 = 1'b1;
                end
                if (exp_wb.valid && ent[u].fu2 == exp_wb.fu) begin
                    ent[u].rdy2 = 1'b1;
                end
            end
        end
        if (exp_wb.valid) begin
            prod[exp_wb.rd] = FU_NONE;
        end
        if (accept) begin
            sent++;
            if (cur.dst != '0) begin
                prod[cur.dst] = cur.fu;
            end
        end
        if (exp_ro.valid) begin
            pend[exp_ro.fu]  = 1'b1;
            delay[exp_ro.fu] = {$random(seed)} % 7;
        end
    endtask

    // unit models, one strobe per read
    task automatic drive_done();
        done = '0;
        for (int u = 1; u <= NUM_FU; u++) begin
            if (pend[u] && delay[u] == 0) begin
                done[u] = 1'b1;
                pend[u] = 1'b0;
            end else if (pend[u]) begin
                delay[u]--;
            end
        end
    endtask

    task automatic drive_inst();
        if (accept || !inst_valid) begin // fetch holds while stalled
            inst_valid = 1'b0;
            cur        = '0;
            if (sent < NUM_INSTS && {$random(seed)} % 4 != 0) begin
                gen_inst();
                inst_valid = 1'b1;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the instruction stream did not drain in time");
    end

    initial begin
        seed       = 32'h4cd7;
        inst       = '0;
        inst_valid = 1'b0;
        done       = '0;
        cur        = '0;
        accept     = 1'b0;
        sent       = 0;
        cycle      = 0;
        for (int u = 1; u <= NUM_FU; u++) begin
            ent[u]   = '0;
            pend[u]  = 1'b0;
            delay[u] = 0;
        end
        for (int r = 0; r < 32; r++) begin
            prod[r] = FU_NONE;
        end
        @(negedge clk);
        check_ready("reset", 1'b1, issue_ready);
        check_ro("reset", '0, ro);
        check_wb("reset", '0, wb);
        @(negedge rst);
        while (sent < NUM_INSTS || inst_valid || model_busy()) begin
            @(posedge clk);
            #2;
            drive_done();
            drive_inst();
            @(negedge clk);
            predict_and_check();
            step_model();
            cycle++;
        end
        // last writeback retired, scoreboard must sit idle
        @(posedge clk);
        @(negedge clk);
        check_ready("drained", 1'b1, issue_ready);
        check_ro("drained", '0, ro);
        check_wb("drained", '0, wb);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rv_isa_pkg.sv
sb_pkg.sv
inst_decoder.sv
reg_result_table.sv
fu_status_table.sv
writeback_arbiter.sv
scoreboard_top.sv
tb_clock_gen.sv
scoreboard_tb.sv
